//--- exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath
`define EXEC_DATA_W 16
`define EXEC_PREG_NUM 64
`define EXEC_PREG_W 6
`define EXEC_ROB_W 6

// alu opcode width
`define EXEC_ALU_OP_W 3

// cycles the multiplier stays busy
`define EXEC_MULT_LAT 3

`endif

//--- exec_types_pkg.sv
`include "exec_settings.svh"

package exec_types_pkg;

	// operand or result word
	typedef logic [`EXEC_DATA_W-1:0] data_t;

	// physical register number
	typedef logic [`EXEC_PREG_W-1:0] preg_t;

	// reorder buffer slot
	typedef logic [`EXEC_ROB_W-1:0] rob_idx_t;

endpackage

//--- exec_ops_pkg.sv
`include "exec_settings.svh"

package exec_ops_pkg;

	typedef enum logic [`EXEC_ALU_OP_W-1:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_shl,
		op_shr,
		op_ldi
	} alu_op_t;

	typedef enum logic [1:0] {
		mult_idle,
		mult_busy,
		mult_done
	} mult_state_t;

endpackage

//--- phys_reg_file.sv
`include "exec_settings.svh"

module phys_reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  exec_types_pkg::preg_t  rd_addr0,
	input  exec_types_pkg::preg_t  rd_addr1,
	input  exec_types_pkg::preg_t  rd_addr2,
	input  exec_types_pkg::preg_t  rd_addr3,
	output exec_types_pkg::data_t  rd_data0,
	output exec_types_pkg::data_t  rd_data1,
	output exec_types_pkg::data_t  rd_data2,
	output exec_types_pkg::data_t  rd_data3,
	input  logic                   wr_en,
	input  exec_types_pkg::preg_t  wr_preg,
	input  exec_types_pkg::data_t  wr_data
);

	exec_types_pkg::data_t regs [`EXEC_PREG_NUM];

	// no bypass, a same-cycle read sees the old value
	assign rd_data0 = regs[rd_addr0];
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];
	assign rd_data3 = regs[rd_addr3];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXEC_PREG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_preg] <= wr_data;
		end
	end

	// write enable comes from the writeback merge registers
	a_wr_en_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(wr_en)
	);

endmodule

//--- alu_lane.sv
module alu_lane (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      issue_valid,
	output logic                      issue_ready,
	input  exec_ops_pkg::alu_op_t     op,
	input  exec_types_pkg::data_t     src1_data,
	input  exec_types_pkg::data_t     src2_data,
	input  exec_types_pkg::data_t     imm,
	input  logic                      imm_vld,
	input  logic                      inv_src2,
	input  logic                      reg_wrt,
	input  exec_types_pkg::preg_t     dst,
	input  exec_types_pkg::rob_idx_t  idx,
	output logic                      res_vld,
	output exec_types_pkg::data_t     res_data,
	output exec_types_pkg::preg_t     res_dst,
	output logic                      res_wrt,
	output exec_types_pkg::rob_idx_t  res_idx,
	input  logic                      take
);

	exec_types_pkg::data_t operand_b;
	exec_types_pkg::data_t alu_out;

	// one result in flight, freed in the cycle it is taken
	assign issue_ready = !res_vld || take;

	always_comb begin
		operand_b = imm_vld ? imm : src2_data;
		if (inv_src2) begin
			operand_b = ~operand_b;
		end
		unique case (op)
			exec_ops_pkg::op_add: alu_out = src1_data + operand_b;
			exec_ops_pkg::op_sub: alu_out = src1_data - operand_b;
			exec_ops_pkg::op_and: alu_out = src1_data & operand_b;
			exec_ops_pkg::op_or:  alu_out = src1_data | operand_b;
			exec_ops_pkg::op_xor: alu_out = src1_data ^ operand_b;
			exec_ops_pkg::op_shl: alu_out = src1_data << operand_b[3:0];
			exec_ops_pkg::op_shr: alu_out = src1_data >> operand_b[3:0];
			exec_ops_pkg::op_ldi: alu_out = imm;
			default:              alu_out = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_vld <= 1'b0;
		end else if (issue_valid && issue_ready) begin
			res_vld <= 1'b1;
		end else if (take) begin
			res_vld <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid && issue_ready) begin
			res_data <= alu_out;
			res_dst  <= dst;
			res_wrt  <= reg_wrt;
			res_idx  <= idx;
		end
	end

endmodule

//--- mult_lane.sv
`include "exec_settings.svh"

module mult_lane (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      issue_valid,
	output logic                      issue_ready,
	input  exec_types_pkg::data_t     src1_data,
	input  exec_types_pkg::data_t     src2_data,
	input  exec_types_pkg::preg_t     dst,
	input  logic                      reg_wrt,
	input  exec_types_pkg::rob_idx_t  idx,
	output logic                      res_vld,
	output exec_types_pkg::data_t     res_data,
	output exec_types_pkg::preg_t     res_dst,
	output logic                      res_wrt,
	output exec_types_pkg::rob_idx_t  res_idx
);

	typedef logic [$clog2(`EXEC_MULT_LAT+1)-1:0] cnt_t;

	exec_ops_pkg::mult_state_t state;
	cnt_t cnt;
	exec_types_pkg::data_t op_a;
	exec_types_pkg::data_t op_b;

	// free flag back to issue
	assign issue_ready = (state == exec_ops_pkg::mult_idle);
	assign res_vld = (state == exec_ops_pkg::mult_done);
	// low half of the product only
	assign res_data = op_a * op_b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= exec_ops_pkg::mult_idle;
			cnt <= '0;
		end else begin
			unique case (state)
				exec_ops_pkg::mult_idle: begin
					if (issue_valid) begin
						state <= exec_ops_pkg::mult_busy;
						// busy cycles plus the done cycle give the latency
						cnt <= cnt_t'(`EXEC_MULT_LAT - 2);
					end
				end
				exec_ops_pkg::mult_busy: begin
					if (cnt == '0) begin
						state <= exec_ops_pkg::mult_done;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= exec_ops_pkg::mult_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid && issue_ready) begin
			op_a    <= src1_data;
			op_b    <= src2_data;
			res_dst <= dst;
			res_wrt <= reg_wrt;
			res_idx <= idx;
		end
	end

	// nothing else gets in until the result has gone out
	a_one_in_flight: assert property (
		@(posedge clk) disable iff (!rst_n)
		(issue_valid && issue_ready) |=>
			(!(issue_valid && issue_ready))[*(`EXEC_MULT_LAT - 1)] ##1
			(res_vld && !(issue_valid && issue_ready))
	);

endmodule

//--- writeback_merge.sv
module writeback_merge (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      alu_res_vld,
	input  exec_types_pkg::data_t     alu_res_data,
	input  exec_types_pkg::preg_t     alu_res_dst,
	input  logic                      alu_res_wrt,
	input  exec_types_pkg::rob_idx_t  alu_res_idx,
	output logic                      alu_take,
	input  logic                      mult_res_vld,
	input  exec_types_pkg::data_t     mult_res_data,
	input  exec_types_pkg::preg_t     mult_res_dst,
	input  logic                      mult_res_wrt,
	input  exec_types_pkg::rob_idx_t  mult_res_idx,
	output logic                      wr_en,
	output exec_types_pkg::preg_t     wr_preg,
	output exec_types_pkg::data_t     wr_data,
	output logic                      done_vld,
	output exec_types_pkg::rob_idx_t  done_idx,
	output exec_types_pkg::data_t     done_data,
	output exec_types_pkg::preg_t     done_preg,
	output logic                      done_wrt
);

	logic hold_full;
	logic hold_load;
	exec_types_pkg::data_t hold_data;
	exec_types_pkg::preg_t hold_dst;
	logic hold_wrt;
	exec_types_pkg::rob_idx_t hold_idx;

	logic sel_vld;
	exec_types_pkg::data_t sel_data;
	exec_types_pkg::preg_t sel_dst;
	logic sel_wrt;
	exec_types_pkg::rob_idx_t sel_idx;

	assign alu_take = !hold_full;
	// alu result parked behind a multiplier result
	assign hold_load = alu_res_vld && mult_res_vld && !hold_full;

	// multiplier first, then the hold, then the live alu result
	always_comb begin
		sel_vld  = 1'b1;
		sel_data = alu_res_data;
		sel_dst  = alu_res_dst;
		sel_wrt  = alu_res_wrt;
		sel_idx  = alu_res_idx;
		if (mult_res_vld) begin
			sel_data = mult_res_data;
			sel_dst  = mult_res_dst;
			sel_wrt  = mult_res_wrt;
			sel_idx  = mult_res_idx;
		end else if (hold_full) begin
			sel_data = hold_data;
			sel_dst  = hold_dst;
			sel_wrt  = hold_wrt;
			sel_idx  = hold_idx;
		end else if (!alu_res_vld) begin
			sel_vld = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_full <= 1'b0;
			done_vld  <= 1'b0;
			done_wrt  <= 1'b0;
		end else begin
			if (hold_load) begin
				hold_full <= 1'b1;
			end else if (hold_full && !mult_res_vld) begin
				hold_full <= 1'b0;
			end
			done_vld <= sel_vld;
			if (sel_vld) begin
				done_wrt <= sel_wrt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hold_load) begin
			hold_data <= alu_res_data;
			hold_dst  <= alu_res_dst;
			hold_wrt  <= alu_res_wrt;
			hold_idx  <= alu_res_idx;
		end
		if (sel_vld) begin
			done_data <= sel_data;
			done_preg <= sel_dst;
			done_idx  <= sel_idx;
		end
	end

	assign wr_en   = done_vld && done_wrt;
	assign wr_preg = done_preg;
	assign wr_data = done_data;

	// relies on the multiplier never producing two results in a row
	a_hold_drains: assert property (
		@(posedge clk) disable iff (!rst_n)
		hold_load |=> hold_full ##1 !hold_full
	);

endmodule

//--- exec_cluster.sv
module exec_cluster (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      alu_valid,
	output logic                      alu_ready,
	input  exec_ops_pkg::alu_op_t     alu_op,
	input  exec_types_pkg::preg_t     alu_src1,
	input  exec_types_pkg::preg_t     alu_src2,
	input  exec_types_pkg::data_t     alu_imm,
	input  logic                      alu_imm_vld,
	input  logic                      alu_inv_src2,
	input  exec_types_pkg::preg_t     alu_dst,
	input  logic                      alu_reg_wrt,
	input  exec_types_pkg::rob_idx_t  alu_idx,
	input  logic                      mult_valid,
	output logic                      mult_ready,
	input  exec_types_pkg::preg_t     mult_src1,
	input  exec_types_pkg::preg_t     mult_src2,
	input  exec_types_pkg::preg_t     mult_dst,
	input  logic                      mult_reg_wrt,
	input  exec_types_pkg::rob_idx_t  mult_idx,
	output logic                      done_vld,
	output exec_types_pkg::rob_idx_t  done_idx,
	output exec_types_pkg::data_t     done_data,
	output exec_types_pkg::preg_t     done_preg,
	output logic                      done_wrt
);

	exec_types_pkg::data_t alu_src1_data;
	exec_types_pkg::data_t alu_src2_data;
	exec_types_pkg::data_t mult_src1_data;
	exec_types_pkg::data_t mult_src2_data;

	logic                     alu_res_vld;
	exec_types_pkg::data_t    alu_res_data;
	exec_types_pkg::preg_t    alu_res_dst;
	logic                     alu_res_wrt;
	exec_types_pkg::rob_idx_t alu_res_idx;
	logic                     alu_take;

	logic                     mult_res_vld;
	exec_types_pkg::data_t    mult_res_data;
	exec_types_pkg::preg_t    mult_res_dst;
	logic                     mult_res_wrt;
	exec_types_pkg::rob_idx_t mult_res_idx;

	logic                     wr_en;
	exec_types_pkg::preg_t    wr_preg;
	exec_types_pkg::data_t    wr_data;

	// ports 0/1 feed the alu, 2/3 the multiplier
	phys_reg_file prf_i (
		.clk(clk), .rst_n(rst_n),
		.rd_addr0(alu_src1), .rd_addr1(alu_src2),
		.rd_addr2(mult_src1), .rd_addr3(mult_src2),
		.rd_data0(alu_src1_data), .rd_data1(alu_src2_data),
		.rd_data2(mult_src1_data), .rd_data3(mult_src2_data),
		.wr_en(wr_en), .wr_preg(wr_preg), .wr_data(wr_data)
	);

	alu_lane alu_i (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(alu_valid), .issue_ready(alu_ready), .op(alu_op),
		.src1_data(alu_src1_data), .src2_data(alu_src2_data), .imm(alu_imm),
		.imm_vld(alu_imm_vld), .inv_src2(alu_inv_src2), .reg_wrt(alu_reg_wrt),
		.dst(alu_dst), .idx(alu_idx),
		.res_vld(alu_res_vld), .res_data(alu_res_data), .res_dst(alu_res_dst),
		.res_wrt(alu_res_wrt), .res_idx(alu_res_idx), .take(alu_take)
	);

	mult_lane mult_i (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(mult_valid), .issue_ready(mult_ready),
		.src1_data(mult_src1_data), .src2_data(mult_src2_data),
		.dst(mult_dst), .reg_wrt(mult_reg_wrt), .idx(mult_idx),
		.res_vld(mult_res_vld), .res_data(mult_res_data), .res_dst(mult_res_dst),
		.res_wrt(mult_res_wrt), .res_idx(mult_res_idx)
	);

	writeback_merge wb_i (
		.clk(clk), .rst_n(rst_n),
		.alu_res_vld(alu_res_vld), .alu_res_data(alu_res_data),
		.alu_res_dst(alu_res_dst), .alu_res_wrt(alu_res_wrt),
		.alu_res_idx(alu_res_idx), .alu_take(alu_take),
		.mult_res_vld(mult_res_vld), .mult_res_data(mult_res_data),
		.mult_res_dst(mult_res_dst), .mult_res_wrt(mult_res_wrt),
		.mult_res_idx(mult_res_idx),
		.wr_en(wr_en), .wr_preg(wr_preg), .wr_data(wr_data),
		.done_vld(done_vld), .done_idx(done_idx), .done_data(done_data),
		.done_preg(done_preg), .done_wrt(done_wrt)
	);

endmodule

//--- tb_exec_cases.svh
// name, lane (0 alu, 1 mult), op, src1, src2, imm, imm_vld, inv_src2,
// dst, reg_wrt, idx, expected data, used again in the back-to-back burst
add_row("ldi_r1",      0, exec_ops_pkg::op_ldi, 0, 0, 16'h1234, 0, 0, 1, 1, 1, 16'h1234, 0);
add_row("ldi_r2",      0, exec_ops_pkg::op_ldi, 0, 0, 16'h00f0, 1, 0, 2, 1, 2, 16'h00f0, 0);
add_row("ldi_r3",      0, exec_ops_pkg::op_ldi, 0, 0, 16'h8001, 0, 0, 3, 1, 3, 16'h8001, 0);
add_row("ldi_r4",      0, exec_ops_pkg::op_ldi, 0, 0, 16'h0005, 1, 0, 4, 1, 4, 16'h0005, 0);
add_row("add_reg",     0, exec_ops_pkg::op_add, 1, 2, 16'h0000, 0, 0, 5, 1, 5, 16'h1324, 1);
add_row("sub_reg",     0, exec_ops_pkg::op_sub, 1, 2, 16'h0000, 0, 0, 6, 1, 6, 16'h1144, 1);
add_row("and_reg",     0, exec_ops_pkg::op_and, 1, 2, 16'h0000, 0, 0, 7, 1, 7, 16'h0030, 1);
add_row("or_reg",      0, exec_ops_pkg::op_or,  1, 2, 16'h0000, 0, 0, 8, 1, 8, 16'h12f4, 1);
add_row("xor_reg",     0, exec_ops_pkg::op_xor, 1, 2, 16'h0000, 0, 0, 9, 1, 9, 16'h12c4, 1);
add_row("shl_reg",     0, exec_ops_pkg::op_shl, 3, 4, 16'h0000, 0, 0, 10, 1, 10, 16'h0020, 1);
add_row("shr_imm",     0, exec_ops_pkg::op_shr, 3, 0, 16'h0004, 1, 0, 11, 1, 11, 16'h0800, 1);
add_row("add_imm_inv", 0, exec_ops_pkg::op_add, 1, 0, 16'h0001, 1, 1, 12, 1, 12, 16'h1232, 1);
add_row("sub_inv",     0, exec_ops_pkg::op_sub, 1, 2, 16'h0000, 0, 1, 13, 1, 13, 16'h1325, 1);
add_row("and_imm",     0, exec_ops_pkg::op_and, 1, 0, 16'h0ff0, 1, 0, 14, 1, 14, 16'h0230, 1);
add_row("shl_low4",    0, exec_ops_pkg::op_shl, 2, 0, 16'h0013, 1, 0, 15, 1, 15, 16'h0780, 1);
add_row("add_no_wrt",  0, exec_ops_pkg::op_add, 1, 0, 16'h0100, 1, 0, 5, 0, 16, 16'h1334, 1);
add_row("read_r5",     0, exec_ops_pkg::op_add, 5, 0, 16'h0000, 1, 0, 16, 1, 17, 16'h1324, 0);
add_row("read_r12",    0, exec_ops_pkg::op_add, 12, 0, 16'h0000, 1, 0, 17, 1, 18, 16'h1232, 0);
add_row("mul_r1_r2",   1, exec_ops_pkg::op_add, 1, 2, 16'h0000, 0, 0, 20, 1, 19, 16'h10c0, 0);
add_row("mul_r3_r4",   1, exec_ops_pkg::op_add, 3, 4, 16'h0000, 0, 0, 21, 1, 20, 16'h8005, 0);
add_row("read_r20",    0, exec_ops_pkg::op_add, 20, 0, 16'h0000, 1, 0, 22, 1, 21, 16'h10c0, 0);

//--- tb_exec_cluster.sv
`include "exec_settings.svh"

module tb_exec_cluster;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		bit                       lane;
		exec_ops_pkg::alu_op_t    op;
		exec_types_pkg::preg_t    src1;
		exec_types_pkg::preg_t    src2;
		exec_types_pkg::data_t    imm;
		bit                       imm_vld;
		bit                       inv;
		exec_types_pkg::preg_t    dst;
		bit                       wrt;
		exec_types_pkg::rob_idx_t idx;
		exec_types_pkg::data_t    exp;
		bit                       burst;
	} row_t;

	localparam int wait_limit = 40;

	logic                     clk;
	logic                     rst_n;
	logic                     alu_valid;
	logic                     alu_ready;
	exec_ops_pkg::alu_op_t    alu_op;
	exec_types_pkg::preg_t    alu_src1;
	exec_types_pkg::preg_t    alu_src2;
	exec_types_pkg::data_t    alu_imm;
	logic                     alu_imm_vld;
	logic                     alu_inv_src2;
	exec_types_pkg::preg_t    alu_dst;
	logic                     alu_reg_wrt;
	exec_types_pkg::rob_idx_t alu_idx;
	logic                     mult_valid;
	logic                     mult_ready;
	exec_types_pkg::preg_t    mult_src1;
	exec_types_pkg::preg_t    mult_src2;
	exec_types_pkg::preg_t    mult_dst;
	logic                     mult_reg_wrt;
	exec_types_pkg::rob_idx_t mult_idx;
	logic                     done_vld;
	exec_types_pkg::rob_idx_t done_idx;
	exec_types_pkg::data_t    done_data;
	exec_types_pkg::preg_t    done_preg;
	logic                     done_wrt;

	row_t                  rows [$];
	string                 row_names [$];
	logic [31:0]           rng_state;
	int                    test_errs;
	int                    total_errs;
	int                    tests_run;
	int                    tests_failed;
	exec_types_pkg::data_t sb_data [64];
	bit                    sb_pend [64];

	exec_cluster dut_i (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_row(string name, int lane, exec_ops_pkg::alu_op_t op, int src1, int src2,
			exec_types_pkg::data_t imm, int imm_vld, int inv, int dst, int wrt, int idx,
			exec_types_pkg::data_t exp, int burst);
		row_t r;
		r.lane = (lane != 0);
		r.op = op;
		r.src1 = exec_types_pkg::preg_t'(src1);
		r.src2 = exec_types_pkg::preg_t'(src2);
		r.imm = imm;
		r.imm_vld = (imm_vld != 0);
		r.inv = (inv != 0);
		r.dst = exec_types_pkg::preg_t'(dst);
		r.wrt = (wrt != 0);
		r.idx = exec_types_pkg::rob_idx_t'(idx);
		r.exp = exp;
		r.burst = (burst != 0);
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic load_table();
		`include "tb_exec_cases.svh"
	endtask

	task automatic check_value(string name, string what, int exp, int act);
		assert (act == exp) else begin
			$display("Mismatch %s %s: expected %0h, actual %0h", name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_true(bit cond, string msg);
		assert (cond) else begin
			$display("%s", msg);
			test_errs++;
		end
	endtask

	task automatic close_test(string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s", name);
			tests_failed++;
		end
		total_errs += test_errs;
		test_errs = 0;
	endtask

	// called at a rising edge, so every input changes through NBAs
	task automatic drive_row(row_t r);
		if (r.lane) begin
			mult_valid <= 1'b1;
			mult_src1 <= r.src1;
			mult_src2 <= r.src2;
			mult_dst <= r.dst;
			mult_reg_wrt <= r.wrt;
			mult_idx <= r.idx;
		end else begin
			alu_valid <= 1'b1;
			alu_op <= r.op;
			alu_src1 <= r.src1;
			alu_src2 <= r.src2;
			alu_imm <= r.imm;
			alu_imm_vld <= r.imm_vld;
			alu_inv_src2 <= r.inv;
			alu_dst <= r.dst;
			alu_reg_wrt <= r.wrt;
			alu_idx <= r.idx;
		end
	endtask

	// returns at the rising edge that accepts the issue
	task automatic wait_accept(bit lane, output bit ok);
		ok = 1'b0;
		for (int i = 0; i < wait_limit && !ok; i++) begin
			@(negedge clk);
			if (lane ? mult_ready : alu_ready) begin
				@(posedge clk);
				ok = 1'b1;
			end
		end
	endtask

	// lat counts cycles from acceptance up to and including done_vld,
	// busy those before it with mult_ready low
	task automatic wait_done(output bit ok, output int lat, output int busy);
		ok = 1'b0;
		lat = 0;
		busy = 0;
		for (int i = 0; i < wait_limit && !ok; i++) begin
			@(negedge clk);
			lat++;
			if (done_vld) begin
				ok = 1'b1;
			end else if (!mult_ready) begin
				busy++;
			end
		end
	endtask

	task automatic check_reset();
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			check_true(alu_ready && mult_ready, "reset: a lane is not ready after reset");
			check_true(!done_vld, "reset: done_vld is high after reset");
		end
		close_test("reset");
	endtask

	task automatic run_row(string name, row_t r);
		bit ok;
		int lat;
		int busy;
		@(posedge clk);
		drive_row(r);
		wait_accept(r.lane, ok);
		alu_valid <= 1'b0;
		mult_valid <= 1'b0;
		check_true(ok, {name, ": issue was never accepted"});
		if (ok) begin
			wait_done(ok, lat, busy);
			check_true(ok, {name, ": no completion arrived"});
		end
		if (ok) begin
			check_value(name, "idx", int'(r.idx), int'(done_idx));
			check_value(name, "data", int'(r.exp), int'(done_data));
			check_value(name, "preg", int'(r.dst), int'(done_preg));
			check_value(name, "wrt", int'(r.wrt), int'(done_wrt));
			check_value(name, "latency", r.lane ? `EXEC_MULT_LAT + 1 : 2, lat);
			if (r.lane) begin
				check_value(name, "mult_ready low cycles", `EXEC_MULT_LAT, busy);
			end
			@(negedge clk);
			check_true(!done_vld, {name, ": done_vld lasted more than one cycle"});
		end
		close_test(name);
	endtask

	task automatic run_collision();
		exec_types_pkg::data_t a;
		exec_types_pkg::data_t b;
		exec_types_pkg::data_t c;
		exec_types_pkg::data_t prod;
		row_t m;
		row_t x;
		bit ok;
		int lat;
		int busy;
		rng_state = xorshift32(rng_state);
		a = exec_types_pkg::data_t'(rng_state);
		rng_state = xorshift32(rng_state);
		b = exec_types_pkg::data_t'(rng_state);
		rng_state = xorshift32(rng_state);
		c = exec_types_pkg::data_t'(rng_state);
		prod = a * b;
		add_row("rand_ldi_a", 0, exec_ops_pkg::op_ldi, 0, 0, a, 1, 0, 30, 1, 30, a, 0);
		run_row(row_names[rows.size() - 1], rows[rows.size() - 1]);
		add_row("rand_ldi_b", 0, exec_ops_pkg::op_ldi, 0, 0, b, 1, 0, 31, 1, 31, b, 0);
		run_row(row_names[rows.size() - 1], rows[rows.size() - 1]);
		add_row("rand_ldi_c", 0, exec_ops_pkg::op_ldi, 0, 0, c, 1, 0, 32, 1, 32, c, 0);
		run_row(row_names[rows.size() - 1], rows[rows.size() - 1]);
		add_row("coll_mul", 1, exec_ops_pkg::op_add, 30, 31, 16'h0000, 0, 0, 33, 1, 50, prod, 0);
		add_row("coll_add", 0, exec_ops_pkg::op_add, 30, 32, 16'h0000, 0, 0, 34, 1, 51, a + c, 0);
		m = rows[rows.size() - 2];
		x = rows[rows.size() - 1];
		@(posedge clk);
		drive_row(m);
		wait_accept(1'b1, ok);
		mult_valid <= 1'b0;
		check_true(ok, "collision: multiplier issue was never accepted");
		// alu accepted LAT-1 edges later, so both lane results meet at the merge
		repeat (`EXEC_MULT_LAT - 2) @(posedge clk);
		drive_row(x);
		wait_accept(1'b0, ok);
		alu_valid <= 1'b0;
		check_true(ok, "collision: ALU issue was never accepted");
		wait_done(ok, lat, busy);
		check_true(ok, "collision: no completion arrived");
		check_value("collision", "first idx", int'(m.idx), int'(done_idx));
		check_value("collision", "first data", int'(m.exp), int'(done_data));
		@(negedge clk);
		check_true(done_vld, "collision: second completion missing in the next cycle");
		check_value("collision", "second idx", int'(x.idx), int'(done_idx));
		check_value("collision", "second data", int'(x.exp), int'(done_data));
		close_test("collision");
	endtask

	task automatic run_burst();
		int expect_n;
		int seen;
		bit ok;
		row_t r;
		expect_n = 0;
		foreach (sb_pend[i]) begin
			sb_pend[i] = 1'b0;
		end
		foreach (rows[i]) begin
			if (rows[i].burst) begin
				expect_n++;
			end
		end
		fork
			begin
				@(posedge clk);
				foreach (rows[i]) begin
					if (rows[i].burst) begin
						r = rows[i];
						r.idx = r.idx + 6'd32;
						sb_data[r.idx] = r.exp;
						sb_pend[r.idx] = 1'b1;
						drive_row(r);
						wait_accept(1'b0, ok);
						check_true(ok, "burst: ALU issue was never accepted");
					end
				end
				alu_valid <= 1'b0;
			end
			begin
				seen = 0;
				for (int i = 0; i < wait_limit && seen < expect_n; i++) begin
					@(negedge clk);
					if (done_vld) begin
						check_true(sb_pend[done_idx], "burst: completion with an unexpected idx");
						check_value("burst", "data", int'(sb_data[done_idx]), int'(done_data));
						sb_pend[done_idx] = 1'b0;
						seen++;
					end
				end
				check_value("burst", "completions", expect_n, seen);
			end
		join
		close_test("burst");
	endtask

	initial begin
		int n_rows;
		clk = 1'b0;
		rst_n <= 1'b0;
		alu_valid <= 1'b0;
		alu_op <= exec_ops_pkg::op_add;
		alu_src1 <= '0;
		alu_src2 <= '0;
		alu_imm <= '0;
		alu_imm_vld <= 1'b0;
		alu_inv_src2 <= 1'b0;
		alu_dst <= '0;
		alu_reg_wrt <= 1'b0;
		alu_idx <= '0;
		mult_valid <= 1'b0;
		mult_src1 <= '0;
		mult_src2 <= '0;
		mult_dst <= '0;
		mult_reg_wrt <= 1'b0;
		mult_idx <= '0;
		rng_state = 32'd34837;
		test_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		load_table();
		n_rows = rows.size();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		check_reset();
		for (int i = 0; i < n_rows; i++) begin
			run_row(row_names[i], rows[i]);
		end
		run_collision();
		run_burst();
		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, total_errs);
		if (total_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+.
exec_types_pkg.sv
exec_ops_pkg.sv
phys_reg_file.sv
alu_lane.sv
mult_lane.sv
writeback_merge.sv
exec_cluster.sv
tb_exec_cluster.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f list.f \
	--top-module tb_exec_cluster --Mdir obj_dir -o sim_exec_cluster; then
	echo "build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_exec_cluster)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "No errors" <<< "$sim_out"; then
	exit 0
fi
echo "pass line not found"
exit 1
